// File: common/aes_macros.svh
/* core-wide sizes for the aes-128 encryption pipeline.
   only 128-bit keys and ten rounds are supported. */
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// one state or key block.
`define AES_BLOCK_W 128

// one column of the state.
`define AES_WORD_W 32

// one byte of the state.
`define AES_BYTE_W 8

// ten rounds, each fed by its own key step.
`define AES_ROUNDS 10

// whitening takes one cycle and every round takes two,
// so the total is 1 + 2 * AES_ROUNDS.
`define AES_LATENCY 21

`endif

// File: common/aes_pkg.sv
/* state types and gf(2^8) helpers for the aes-128 stages.
   the s-box is computed as inverse plus affine map, so no table is stored. */
`include "aes_macros.svh"

package aes_pkg;

    // state geometry.
    localparam int ROWS = `AES_WORD_W / `AES_BYTE_W;
    localparam int COLS = `AES_BLOCK_W / `AES_WORD_W;

    typedef logic [`AES_BYTE_W-1:0] byte_t;

    // byte 0 is the most significant byte of a column.
    typedef byte_t [0:ROWS-1] word_t;

    // word 0 is the most significant column of a block.
    typedef word_t [0:COLS-1] block_t;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1.
    function automatic byte_t xtime(input byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // shift-and-add product in gf(2^8).
    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t p;
        byte_t m;
        p = '0;
        m = a;
        for (int i = 0; i < `AES_BYTE_W; i++)
        begin
            if (b[i])
            begin
                p = p ^ m;
            end
            m = xtime(m);
        end
        return p;
    endfunction

    // inverse as a^254, built from the squares a^2 .. a^128.
    // zero maps to zero, as the s-box needs.
    function automatic byte_t gf_inv(input byte_t a);
        byte_t sq;
        byte_t acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < `AES_BYTE_W; i++)
        begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // forward s-box.
    function automatic byte_t sbox(input byte_t a);
        byte_t b;
        byte_t s;
        b = gf_inv(a);
        // affine map: b plus its rotations by one to four bits, plus 63.
        s = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]};
        s = s ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]};
        return s ^ 8'h63;
    endfunction

    // round constant for key step 1 to 10.
    function automatic byte_t rcon_of(input int step);
        byte_t r;
        r = 8'h01;
        for (int i = 2; i <= `AES_ROUNDS; i++)
        begin
            if (i <= step)
            begin
                r = xtime(r);
            end
        end
        return r;
    endfunction

endpackage

// File: list.f
+incdir+common
common/aes_pkg.sv
rtl/aes_key_step.sv
rtl/aes_round.sv
rtl/aes_final_round.sv
rtl/aes_core.sv
sim/aes_checker.sv
sim/aes_tb.sv

// File: rtl/aes_core.sv
/* fully pipelined aes-128 encryption, one block per clock, fixed 21-cycle latency.
   no back-pressure: ciphertext is shown for exactly one cycle with out_valid. */
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_core
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  block_t plaintext,
    input  block_t key,
    output logic   out_valid,
    output block_t ciphertext
);

    // entry 0 is the whitening stage, entry i the output of step or round i.
    block_t key_chain   [0:`AES_ROUNDS-1];
    block_t state_chain [0:`AES_ROUNDS-1];
    block_t round_keys  [1:`AES_ROUNDS];

    logic [`AES_LATENCY-1:0] valid_q;

    // input whitening; the key is held alongside for step 1.
    always_ff @(posedge clk)
    begin
        state_chain[0] <= plaintext ^ key;
        key_chain[0]   <= key;
    end

    genvar i;

    generate
        for (i = 1; i <= `AES_ROUNDS; i++)
        begin : g_key
            if (i < `AES_ROUNDS)
            begin : g_mid
                aes_key_step #(
                    .STEP (i)
                ) u_key_step (
                    .clk       (clk),
                    .key_in    (key_chain[i-1]),
                    .round_key (round_keys[i]),
                    .key_out   (key_chain[i])
                );
            end
            else
            begin : g_last
                // nothing follows the last step.
                aes_key_step #(
                    .STEP (i)
                ) u_key_step (
                    .clk       (clk),
                    .key_in    (key_chain[i-1]),
                    .round_key (round_keys[i]),
                    .key_out   ()
                );
            end
        end
    endgenerate

    generate
        for (i = 1; i < `AES_ROUNDS; i++)
        begin : g_round
            aes_round u_round (
                .clk       (clk),
                .state_in  (state_chain[i-1]),
                .round_key (round_keys[i]),
                .state_out (state_chain[i])
            );
        end
    endgenerate

    aes_final_round u_final_round (
        .clk       (clk),
        .state_in  (state_chain[`AES_ROUNDS-1]),
        .round_key (round_keys[`AES_ROUNDS]),
        .state_out (ciphertext)
    );

    // valid travels beside the data, one bit per register stage.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q <= {valid_q[`AES_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_q[`AES_LATENCY-1];

    // a reset in between drops the attempt, so flushed blocks are not expected.
    property p_valid_latency;
        logic v;
        (1'b1, v = in_valid) |-> ##`AES_LATENCY (out_valid == v);
    endproperty

    a_valid_latency : assert property (
        @(posedge clk) disable iff (!rst_n) p_valid_latency
    ) else $error("out_valid does not follow in_valid by the pipeline latency.");

    // every stage and key step must have carried real data.
    a_ciphertext_known : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> !$isunknown(ciphertext)
    ) else $error("ciphertext has unknown bits while out_valid is high.");

endmodule

// File: rtl/aes_final_round.sv
/* last aes round in two cycles, without mixcolumns.
   round_key is the tenth round key, sampled one cycle after state_in. */
`timescale 1ns/1ps

module aes_final_round
    import aes_pkg::*;
(
    input  logic   clk,
    input  block_t state_in,
    input  block_t round_key,
    output block_t state_out
);

    block_t sb_q;
    block_t shifted;

    // registered s-box of all sixteen bytes.
    always_ff @(posedge clk)
    begin
        for (int c = 0; c < COLS; c++)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                sb_q[c][r] <= sbox(state_in[c][r]);
            end
        end
    end

    // gather bytes in shiftrows order.
    always_comb
    begin
        for (int c = 0; c < COLS; c++)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                shifted[c][r] = sb_q[(c + r) % COLS][r];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        state_out <= shifted ^ round_key;
    end

endmodule

// File: rtl/aes_key_step.sv
/* one aes-128 key expansion step, two cycles from key_in to key_out.
   round_key is valid one cycle after key_in. */
`timescale 1ns/1ps

module aes_key_step
    import aes_pkg::*;
#(
    parameter int STEP = 1
)
(
    input  logic   clk,
    input  block_t key_in,
    output block_t round_key,
    output block_t key_out
);

    localparam byte_t RCON = rcon_of(STEP);

    block_t pre;
    block_t pre_q;
    word_t  rot_w;
    word_t  sub_q;

    // prefix xor of the four words, rcon folded into the top byte of word 0.
    always_comb
    begin
        pre[0]    = key_in[0];
        pre[0][0] = key_in[0][0] ^ RCON;
        for (int w = 1; w < COLS; w++)
        begin
            pre[w] = pre[w-1] ^ key_in[w];
        end
    end

    // rotword of the last column.
    assign rot_w = {key_in[COLS-1][1], key_in[COLS-1][2], key_in[COLS-1][3], key_in[COLS-1][0]};

    always_ff @(posedge clk)
    begin
        pre_q <= pre;
        for (int r = 0; r < ROWS; r++)
        begin
            sub_q[r] <= sbox(rot_w[r]);
        end
    end

    // the substituted word lands in every column.
    always_comb
    begin
        for (int w = 0; w < COLS; w++)
        begin
            round_key[w] = pre_q[w] ^ sub_q;
        end
    end

    always_ff @(posedge clk)
    begin
        key_out <= round_key;
    end

endmodule

// File: rtl/aes_round.sv
/* one full aes round in two cycles: byte lookups, then shiftrows, mixcolumns
   and the round key xor. round_key is sampled one cycle after state_in. */
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_round
    import aes_pkg::*;
(
    input  logic   clk,
    input  block_t state_in,
    input  block_t round_key,
    output block_t state_out
);

    block_t sb;
    block_t sb_q;
    block_t sx_q;
    word_t  entry [COLS][ROWS];
    block_t mixed;

    always_comb
    begin
        for (int c = 0; c < COLS; c++)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                sb[c][r] = sbox(state_in[c][r]);
            end
        end
    end

    // registered lookup: s and s times x per byte.
    always_ff @(posedge clk)
    begin
        sb_q <= sb;
        for (int c = 0; c < COLS; c++)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                sx_q[c][r] <= xtime(sb[c][r]);
            end
        end
    end

    // table entry {2s, s, s, 3s}, rotated right by one byte per row.
    always_comb
    begin
        word_t                      base;
        logic [2*`AES_WORD_W-1:0]   twice;
        for (int c = 0; c < COLS; c++)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                base        = {sx_q[c][r], sb_q[c][r], sb_q[c][r], sx_q[c][r] ^ sb_q[c][r]};
                twice       = {base, base};
                entry[c][r] = twice[`AES_BYTE_W*r +: `AES_WORD_W];
            end
        end
    end

    // row r of output column c comes from input column c + r (shiftrows).
    always_comb
    begin
        for (int c = 0; c < COLS; c++)
        begin
            mixed[c] = round_key[c];
            for (int r = 0; r < ROWS; r++)
            begin
                mixed[c] = mixed[c] ^ entry[(c + r) % COLS][r];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        state_out <= mixed;
    end

endmodule

// File: sim/aes_checker.sv
/* watches the aes core ports and compares every output with a fips-197 model.
   expected blocks are kept in sampling order, so outputs must not reorder. */
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_checker
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [`AES_BLOCK_W-1:0] plaintext,
    input  logic [`AES_BLOCK_W-1:0] key,
    input  logic                    out_valid,
    input  logic [`AES_BLOCK_W-1:0] ciphertext,
    output int                      checks,
    output int                      errors,
    output int                      pending
);

    localparam logic [`AES_BLOCK_W-1:0] KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [`AES_BLOCK_W-1:0] KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [`AES_BLOCK_W-1:0] KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    string                   test_name = "startup";
    logic [7:0]              sbox_tab [256];
    logic [`AES_BLOCK_W-1:0] exp_q [$];
    int                      cyc_q [$];
    int                      cycle = 0;

    function automatic logic [7:0] mul2(input logic [7:0] a);
        return a[7] ? ((a << 1) ^ 8'h1b) : (a << 1);
    endfunction

    // horner form, most significant bit of b first.
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        p = 8'h00;
        for (int i = 7; i >= 0; i--)
        begin
            p = mul2(p) ^ (b[i] ? a : 8'h00);
        end
        return p;
    endfunction

    function automatic logic [`AES_BLOCK_W-1:0] encrypt(input logic [`AES_BLOCK_W-1:0] pt,
                                                        input logic [`AES_BLOCK_W-1:0] k);
        logic [31:0] w [44];
        logic [31:0] t;
        logic [7:0]  rc;
        logic [7:0]  st [16];
        logic [7:0]  sh [16];
        logic [`AES_BLOCK_W-1:0] res;
        rc = 8'h01;
        for (int i = 0; i < 4; i++)
        begin
            w[i] = k[127-32*i -: 32];
        end
        for (int i = 4; i < 44; i++)
        begin
            t = w[i-1];
            if (i % 4 == 0)
            begin
                t = {sbox_tab[t[23:16]], sbox_tab[t[15:8]], sbox_tab[t[7:0]], sbox_tab[t[31:24]]};
                t = t ^ {rc, 24'h0};
                rc = mul2(rc);
            end
            w[i] = w[i-4] ^ t;
        end
        for (int b = 0; b < 16; b++)
        begin
            st[b] = pt[127-8*b -: 8] ^ w[b/4][31-8*(b%4) -: 8];
        end
        for (int rnd = 1; rnd <= `AES_ROUNDS; rnd++)
        begin
            // subbytes and shiftrows, byte index is 4 * column + row.
            for (int b = 0; b < 16; b++)
            begin
                sh[b] = sbox_tab[st[4*((b/4 + b%4) % 4) + b%4]];
            end
            for (int c = 0; c < 4; c++)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    if (rnd < `AES_ROUNDS)
                        st[4*c+r] = mul2(sh[4*c+r]) ^ gmul(sh[4*c+(r+1)%4], 8'h03)
                                    ^ sh[4*c+(r+2)%4] ^ sh[4*c+(r+3)%4];
                    else
                        st[4*c+r] = sh[4*c+r];
                    st[4*c+r] = st[4*c+r] ^ w[4*rnd+c][31-8*r -: 8];
                end
            end
        end
        for (int b = 0; b < 16; b++)
        begin
            res[127-8*b -: 8] = st[b];
        end
        return res;
    endfunction

    // s-box from a brute-force inverse and the affine map of fips-197.
    initial
    begin
        logic [7:0] inv;
        logic [7:0] s;
        checks  = 0;
        errors  = 0;
        pending = 0;
        for (int a = 0; a < 256; a++)
        begin
            inv = 8'h00;
            for (int b = 1; b < 256; b++)
            begin
                if (gmul(a[7:0], b[7:0]) == 8'h01)
                    inv = b[7:0];
            end
            for (int i = 0; i < 8; i++)
            begin
                s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
            end
            sbox_tab[a] = s ^ 8'h63;
        end
        if (encrypt(KAT_PT, KAT_KEY) !== KAT_CT)
        begin
            $display("reference model does not reproduce the fips-197 known answer");
            errors++;
        end
    end

    always @(posedge clk)
    begin
        logic [`AES_BLOCK_W-1:0] exp_ct;
        int                      age;
        if (!rst_n)
        begin
            if (out_valid)
            begin
                $display("%s: out_valid is high while reset is asserted", test_name);
                errors++;
            end
            exp_q.delete();
            cyc_q.delete();
        end
        else
        begin
            if (out_valid && exp_q.size() == 0)
            begin
                $display("%s: out_valid with no block outstanding", test_name);
                errors++;
            end
            else if (out_valid)
            begin
                exp_ct = exp_q.pop_front();
                age    = cycle - cyc_q.pop_front();
                checks++;
                if (age != `AES_LATENCY)
                begin
                    $display("ERR %s: latency expected %0d actual %0d",
                             test_name, `AES_LATENCY, age);
                    errors++;
                end
                if (ciphertext !== exp_ct)
                begin
                    $display("ERR %s: ciphertext expected %h actual %h",
                             test_name, exp_ct, ciphertext);
                    errors++;
                end
            end
            else if (cyc_q.size() > 0 && cycle - cyc_q[0] >= `AES_LATENCY)
            begin
                // the block's slot has passed without out_valid.
                $display("%s: no output for the block sampled at cycle %0d", test_name, cyc_q[0]);
                errors++;
                void'(exp_q.pop_front());
                void'(cyc_q.pop_front());
            end
            if (in_valid)
            begin
                exp_q.push_back(encrypt(plaintext, key));
                cyc_q.push_back(cycle);
            end
        end
        pending = exp_q.size();
        cycle++;
    end

endmodule

// File: sim/aes_tb.sv
/* drives the aes core with a known vector and seeded random blocks on falling edges.
   all comparisons are made by aes_checker. */
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_tb;

    localparam logic [31:0] SEED          = 32'h8f9f_bf8f;
    localparam int          DRAIN_TIMEOUT = 200;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic [`AES_BLOCK_W-1:0] plaintext;
    logic [`AES_BLOCK_W-1:0] key;
    logic                    out_valid;
    logic [`AES_BLOCK_W-1:0] ciphertext;
    int                      checks;
    int                      errors;
    int                      pending;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      err_base;
    int                      chk_base;

    aes_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    aes_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext),
        .checks     (checks),
        .errors     (errors),
        .pending    (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    function automatic logic [`AES_BLOCK_W-1:0] rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // one cycle of stimulus.
    task automatic drive(input logic v, input logic [`AES_BLOCK_W-1:0] pt,
                         input logic [`AES_BLOCK_W-1:0] k);
        @(negedge clk);
        in_valid  = v;
        plaintext = pt;
        key       = k;
    endtask

    task automatic start_test(input string name);
        u_checker.test_name = name;
        err_base = errors;
        chk_base = checks;
    endtask

    // idles the input until every queued block is out, then reports.
    task automatic finish_test(input string name, input int sent);
        int waited;
        drive(1'b0, rand_block(), rand_block());
        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        tests_run++;
        if (pending != 0)
        begin
            $display("test %s: timed out with %0d blocks in flight", name, pending);
            tests_failed++;
        end
        else if (errors != err_base || checks - chk_base != sent)
        begin
            $display("test %s: failed, %0d errors, %0d of %0d outputs seen",
                     name, errors - err_base, checks - chk_base, sent);
            tests_failed++;
        end
        else
            $display("test %s: passed, %0d outputs", name, sent);
    endtask

    initial
    begin
        int  sent;
        logic v;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        plaintext = '0;
        key       = '0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("known vector");
        drive(1'b1, 128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f);
        finish_test("known vector", 1);

        // each block is followed by at least a full pipeline of idle cycles.
        start_test("fixed latency");
        for (int i = 0; i < 5; i++)
        begin
            drive(1'b1, rand_block(), rand_block());
            repeat ($urandom_range(`AES_LATENCY, `AES_LATENCY + 4))
                drive(1'b0, rand_block(), rand_block());
        end
        finish_test("fixed latency", 5);

        start_test("back-to-back");
        repeat (200) drive(1'b1, rand_block(), rand_block());
        finish_test("back-to-back", 200);

        start_test("gapped input");
        sent = 0;
        repeat (200)
        begin
            v = $urandom_range(0, 1);
            sent += v;
            drive(v, rand_block(), rand_block());
        end
        finish_test("gapped input", sent);

        // the reset hits while fewer blocks than the latency are in flight.
        start_test("reset flush");
        repeat (15) drive(1'b1, rand_block(), rand_block());
        @(negedge clk);
        rst_n    = 1'b0;
        in_valid = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (10) drive(1'b1, rand_block(), rand_block());
        finish_test("reset flush", 10);

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
